//--- hdl/soc_bus_pkg.sv
package soc_bus_pkg;

  ////////////////////
  // bus widths
  ////////////////////
  // byte address and data word of the peripheral bus
  localparam int CFG_ADDR_BITS = 16;
  localparam int CFG_DATA_BITS = 32;

  // region field that selects one slave slot
  localparam int CFG_REGION_MSB = 15;
  localparam int CFG_REGION_LSB = 12;
  localparam int CFG_REGION_BITS = CFG_REGION_MSB - CFG_REGION_LSB + 1;

  // register offset inside one region
  typedef logic [CFG_REGION_LSB-1:0] reg_off_t;

  ////////////////////
  // address map
  ////////////////////
  // region values, every other region is unmapped
  localparam int CFG_SLOT_PNP = 0;
  localparam int CFG_SLOT_GPIO = 1;
  localparam int CFG_SLOT_TIMER = 2;
  localparam int CFG_SLOT_IRQ = 3;
  localparam int CFG_SLV_TOTAL = 4;

  // device ids reported by the configuration table
  localparam int CFG_DEV_ID_BITS = 16;
  localparam logic [CFG_DEV_ID_BITS-1:0] DEV_ID_PNP = 16'h0071;
  localparam logic [CFG_DEV_ID_BITS-1:0] DEV_ID_GPIO = 16'h0060;
  localparam logic [CFG_DEV_ID_BITS-1:0] DEV_ID_TIMER = 16'h0010;
  localparam logic [CFG_DEV_ID_BITS-1:0] DEV_ID_IRQ = 16'h0011;

  // interrupt source ids, id 0 means no interrupt
  localparam int IRQ_ID_GPIO = 1;
  localparam int IRQ_ID_TIMER = 2;
  localparam int IRQ_ID_EXT = 3;
  localparam int CFG_IRQ_TOTAL = 4;
  localparam int CFG_IRQ_ID_BITS = $clog2(CFG_IRQ_TOTAL);

  ////////////////////
  // register offsets
  ////////////////////
  // configuration table, one device id word per slot from DEV_BASE on
  localparam reg_off_t PNP_REG_HW_ID = 12'h000;
  localparam reg_off_t PNP_REG_SLV_TOTAL = 12'h004;
  localparam reg_off_t PNP_REG_DEV_BASE = 12'h008;

  // gpio
  localparam reg_off_t GPIO_REG_IN = 12'h000;
  localparam reg_off_t GPIO_REG_OUT = 12'h004;
  localparam reg_off_t GPIO_REG_DIR = 12'h008;
  localparam reg_off_t GPIO_REG_IE = 12'h00C;
  localparam reg_off_t GPIO_REG_PEND = 12'h010;

  // machine timer
  localparam reg_off_t TIMER_REG_MTIME_LO = 12'h000;
  localparam reg_off_t TIMER_REG_MTIME_HI = 12'h004;
  localparam reg_off_t TIMER_REG_CMP_LO = 12'h008;
  localparam reg_off_t TIMER_REG_CMP_HI = 12'h00C;

  // interrupt controller
  localparam reg_off_t IRQ_REG_PENDING = 12'h000;
  localparam reg_off_t IRQ_REG_ENABLE = 12'h004;
  localparam reg_off_t IRQ_REG_CLAIM = 12'h008;

endpackage

//--- hdl/wb_slave_if.sv
`timescale 1ns/1ns

// one wishbone classic link between the bus controller and a slave
interface wb_slave_if;
  import soc_bus_pkg::*;

  // request side, held stable by the master until ack
  logic cyc;
  logic stb;
  logic we;
  logic [CFG_ADDR_BITS-1:0] adr;
  logic [CFG_DATA_BITS-1:0] dat_w;

  // response side, registered inside the slave
  logic ack;
  logic [CFG_DATA_BITS-1:0] dat_r;

  // controller end
  modport master (
    output cyc, stb, we, adr, dat_w,
    input  ack, dat_r
  );

  // peripheral end
  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output ack, dat_r
  );

endinterface

//--- hdl/wb_bus_ctrl.sv
`timescale 1ns/1ns

module wb_bus_ctrl
(
  input  logic                                   i_sys_clk,
  input  logic                                   i_rst,
  // single master port
  input  logic                                   i_cyc,
  input  logic                                   i_stb,
  input  logic                                   i_we,
  input  logic [soc_bus_pkg::CFG_ADDR_BITS-1:0]  i_adr,
  input  logic [soc_bus_pkg::CFG_DATA_BITS-1:0]  i_dat,
  output logic [soc_bus_pkg::CFG_DATA_BITS-1:0]  o_dat,
  output logic                                   o_ack,
  output logic                                   o_err,
  // one link per slot
  wb_slave_if.master                             slaves [soc_bus_pkg::CFG_SLV_TOTAL]
);
  import soc_bus_pkg::*;

  logic [CFG_REGION_BITS-1:0] region;
  logic [CFG_SLV_TOTAL-1:0] sel;
  logic [CFG_SLV_TOTAL-1:0] ack_vec;
  logic [CFG_DATA_BITS-1:0] rdata_vec [CFG_SLV_TOTAL];
  logic hit;
  logic err_q;

  ////////////////////
  // region decode
  ////////////////////
  // upper address bits pick the slot
  assign region = i_adr[CFG_REGION_MSB:CFG_REGION_LSB];

  genvar g;
  generate
    for (g = 0; g < CFG_SLV_TOTAL; g++)
    begin : g_slot
      // slot number equals region value
      assign sel[g] = (region == CFG_REGION_BITS'(g));

      // cyc is broadcast, only the selected slot sees a strobe
      assign slaves[g].cyc = i_cyc;
      assign slaves[g].stb = i_stb & sel[g];
      assign slaves[g].we = i_we;
      assign slaves[g].adr = i_adr;
      assign slaves[g].dat_w = i_dat;

      // collect responses for the return mux
      assign ack_vec[g] = slaves[g].ack & sel[g];
      assign rdata_vec[g] = slaves[g].dat_r;
    end
  endgenerate

  // any mapped slot hit
  assign hit = |sel;

  ////////////////////
  // unmapped regions
  ////////////////////
  // err answers one cycle after the strobe, like a slave ack
  // the ~err_q term keeps it to a single cycle pulse
  always_ff @(posedge i_sys_clk)
  begin
    if (i_rst)
    begin
      err_q <= 1'b0;
    end
    else
    begin
      err_q <= i_cyc & i_stb & ~hit & ~err_q;
    end
  end

  assign o_err = err_q;

  ////////////////////
  // response mux
  ////////////////////
  // the address is held until the response, so sel is still valid here
  assign o_ack = |ack_vec;

  // read data from the selected slot, zero for an unmapped region
  always_comb
  begin
    o_dat = '0;
    for (int i = 0; i < CFG_SLV_TOTAL; i++)
    begin
      if (sel[i])
      begin
        o_dat = rdata_vec[i];
      end
    end
  end

endmodule

//--- hdl/wb_pnp.sv
`timescale 1ns/1ns

module wb_pnp
#(
  parameter logic [soc_bus_pkg::CFG_DATA_BITS-1:0] HW_ID = 32'h20240001
)
(
  input  logic       i_sys_clk,
  input  logic       i_rst,
  wb_slave_if.slave  bus
);
  import soc_bus_pkg::*;

  reg_off_t offset;
  logic req;
  logic [CFG_DATA_BITS-1:0] rdata;
  logic [CFG_DEV_ID_BITS-1:0] dev_tab [CFG_SLV_TOTAL];

  // device ids in slot order
  assign dev_tab[CFG_SLOT_PNP] = DEV_ID_PNP;
  assign dev_tab[CFG_SLOT_GPIO] = DEV_ID_GPIO;
  assign dev_tab[CFG_SLOT_TIMER] = DEV_ID_TIMER;
  assign dev_tab[CFG_SLOT_IRQ] = DEV_ID_IRQ;

  assign offset = bus.adr[CFG_REGION_LSB-1:0];
  // new request, writes land here too and are simply dropped
  assign req = bus.cyc & bus.stb & ~bus.ack;

  // read-only table
  always_comb
  begin
    rdata = '0;
    if (offset == PNP_REG_HW_ID)
      rdata = HW_ID;
    else if (offset == PNP_REG_SLV_TOTAL)
      rdata = CFG_DATA_BITS'(CFG_SLV_TOTAL);
    else
    begin
      for (int i = 0; i < CFG_SLV_TOTAL; i++)
      begin
        if (offset == PNP_REG_DEV_BASE + reg_off_t'(4 * i))
          rdata = {{(CFG_DATA_BITS - CFG_DEV_ID_BITS){1'b0}}, dev_tab[i]};
      end
    end
  end

  // ack one cycle after the strobe
  always_ff @(posedge i_sys_clk)
  begin
    if (i_rst)
      bus.ack <= 1'b0;
    else
      bus.ack <= req;
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (req)
      bus.dat_r <= rdata;
  end

endmodule

//--- hdl/wb_gpio.sv
`timescale 1ns/1ns

module wb_gpio
#(
  parameter int GPIO_WIDTH = 12
)
(
  input  logic                   i_sys_clk,
  input  logic                   i_rst,
  wb_slave_if.slave              bus,
  input  logic [GPIO_WIDTH-1:0]  i_gpio,
  output logic [GPIO_WIDTH-1:0]  o_gpio,
  output logic [GPIO_WIDTH-1:0]  o_gpio_dir,
  output logic                   o_irq
);
  import soc_bus_pkg::*;

  reg_off_t offset;
  logic req;
  logic wr;
  logic [CFG_DATA_BITS-1:0] rdata;
  logic [GPIO_WIDTH-1:0] gpio_meta;
  logic [GPIO_WIDTH-1:0] gpio_sync;
  logic [GPIO_WIDTH-1:0] gpio_prev;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] ie_q;
  logic [GPIO_WIDTH-1:0] pend_q;
  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] pend_clr;

  assign offset = bus.adr[CFG_REGION_LSB-1:0];
  assign req = bus.cyc & bus.stb & ~bus.ack;
  assign wr = req & bus.we;

  // rising edge seen after the synchroniser
  assign rise = gpio_sync & ~gpio_prev;
  // write one to clear
  assign pend_clr = (wr && offset == GPIO_REG_PEND) ? bus.dat_w[GPIO_WIDTH-1:0] : '0;

  always_ff @(posedge i_sys_clk)
  begin
    if (i_rst)
    begin
      gpio_meta <= '0;
      gpio_sync <= '0;
      gpio_prev <= '0;
      out_q <= '0;
      dir_q <= '0;
      ie_q <= '0;
      pend_q <= '0;
      bus.ack <= 1'b0;
    end
    else
    begin
      // two flop synchroniser, then one more for the edge
      gpio_meta <= i_gpio;
      gpio_sync <= gpio_meta;
      gpio_prev <= gpio_sync;
      if (wr && offset == GPIO_REG_OUT)
        out_q <= bus.dat_w[GPIO_WIDTH-1:0];
      if (wr && offset == GPIO_REG_DIR)
        dir_q <= bus.dat_w[GPIO_WIDTH-1:0];
      if (wr && offset == GPIO_REG_IE)
        ie_q <= bus.dat_w[GPIO_WIDTH-1:0];
      // a new edge wins over a clear in the same cycle
      pend_q <= (pend_q & ~pend_clr) | rise;
      bus.ack <= req;
    end
  end

  ////////////////////
  // read mux
  ////////////////////
  always_comb
  begin
    rdata = '0;
    case (offset)
      GPIO_REG_IN:   rdata[GPIO_WIDTH-1:0] = gpio_sync;
      GPIO_REG_OUT:  rdata[GPIO_WIDTH-1:0] = out_q;
      GPIO_REG_DIR:  rdata[GPIO_WIDTH-1:0] = dir_q;
      GPIO_REG_IE:   rdata[GPIO_WIDTH-1:0] = ie_q;
      GPIO_REG_PEND: rdata[GPIO_WIDTH-1:0] = pend_q;
      default:       rdata = '0;
    endcase
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (req)
      bus.dat_r <= rdata;
  end

  assign o_gpio = out_q;
  assign o_gpio_dir = dir_q;
  // level request while any enabled bit is pending
  assign o_irq = |(pend_q & ie_q);

endmodule

//--- hdl/wb_timer.sv
`timescale 1ns/1ns

module wb_timer
(
  input  logic       i_sys_clk,
  input  logic       i_rst,
  wb_slave_if.slave  bus,
  output logic       o_mtip
);
  import soc_bus_pkg::*;

  reg_off_t offset;
  logic req;
  logic wr;
  logic [CFG_DATA_BITS-1:0] rdata;
  logic [63:0] mtime_q;
  logic [63:0] cmp_q;

  assign offset = bus.adr[CFG_REGION_LSB-1:0];
  assign req = bus.cyc & bus.stb & ~bus.ack;
  assign wr = req & bus.we;

  ////////////////////
  // counter and compare
  ////////////////////
  // free running, one tick per clock
  always_ff @(posedge i_sys_clk)
  begin
    if (i_rst)
    begin
      mtime_q <= '0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // compare starts at all ones so no interrupt out of reset
  always_ff @(posedge i_sys_clk)
  begin
    if (i_rst)
    begin
      cmp_q <= '1;
    end
    else
    begin
      if (wr && offset == TIMER_REG_CMP_LO)
        cmp_q[31:0] <= bus.dat_w;
      if (wr && offset == TIMER_REG_CMP_HI)
        cmp_q[63:32] <= bus.dat_w;
    end
  end

  // halves are read separately, software handles the carry
  always_comb
  begin
    case (offset)
      TIMER_REG_MTIME_LO: rdata = mtime_q[31:0];
      TIMER_REG_MTIME_HI: rdata = mtime_q[63:32];
      TIMER_REG_CMP_LO:   rdata = cmp_q[31:0];
      TIMER_REG_CMP_HI:   rdata = cmp_q[63:32];
      default:            rdata = '0;
    endcase
  end

  // bus response
  always_ff @(posedge i_sys_clk)
  begin
    if (i_rst)
      bus.ack <= 1'b0;
    else
      bus.ack <= req;
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (req)
      bus.dat_r <= rdata;
  end

  // Stays high until compare is moved past the counter.
  assign o_mtip = (mtime_q >= cmp_q);

endmodule

//--- hdl/wb_irq_ctrl.sv
`timescale 1ns/1ns

module wb_irq_ctrl
(
  input  logic                                   i_sys_clk,
  input  logic                                   i_rst,
  wb_slave_if.slave                              bus,
  input  logic [soc_bus_pkg::CFG_IRQ_TOTAL-1:0]  i_irq,
  output logic                                   o_meip
);
  import soc_bus_pkg::*;

  reg_off_t offset;
  logic req;
  logic wr;
  logic claim_rd;
  logic [CFG_DATA_BITS-1:0] rdata;
  logic [CFG_IRQ_TOTAL-1:0] irq_prev;
  logic [CFG_IRQ_TOTAL-1:0] pend_q;
  logic [CFG_IRQ_TOTAL-1:0] en_q;
  logic [CFG_IRQ_TOTAL-1:0] pend_en;
  logic [CFG_IRQ_TOTAL-1:0] rise;
  logic [CFG_IRQ_TOTAL-1:0] claim_clr;
  logic [CFG_IRQ_ID_BITS-1:0] claim_id;

  assign offset = bus.adr[CFG_REGION_LSB-1:0];
  assign req = bus.cyc & bus.stb & ~bus.ack;
  assign wr = req & bus.we;
  assign claim_rd = req & ~bus.we & (offset == IRQ_REG_CLAIM);

  // sources are levels, only their rising edge is latched
  assign rise = i_irq & ~irq_prev;
  assign pend_en = pend_q & en_q;

  ////////////////////
  // claim
  ////////////////////
  // walk down so the lowest id is left in claim_id
  // id 0 is never a candidate
  always_comb
  begin
    claim_id = '0;
    for (int i = CFG_IRQ_TOTAL - 1; i > 0; i--)
    begin
      if (pend_en[i])
        claim_id = CFG_IRQ_ID_BITS'(i);
    end
  end

  // claimed id is dropped from pending with the same ack
  always_comb
  begin
    claim_clr = '0;
    if (claim_rd && claim_id != '0)
      claim_clr[claim_id] = 1'b1;
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (i_rst)
    begin
      irq_prev <= '0;
      pend_q <= '0;
      en_q <= '0;
      bus.ack <= 1'b0;
    end
    else
    begin
      irq_prev <= i_irq;
      // fresh edge beats a claim in the same cycle
      pend_q <= (pend_q & ~claim_clr) | rise;
      if (wr && offset == IRQ_REG_ENABLE)
        en_q <= bus.dat_w[CFG_IRQ_TOTAL-1:0];
      bus.ack <= req;
    end
  end

  // read mux
  always_comb
  begin
    rdata = '0;
    case (offset)
      IRQ_REG_PENDING: rdata[CFG_IRQ_TOTAL-1:0] = pend_q;
      IRQ_REG_ENABLE:  rdata[CFG_IRQ_TOTAL-1:0] = en_q;
      IRQ_REG_CLAIM:   rdata[CFG_IRQ_ID_BITS-1:0] = claim_id;
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (req)
      bus.dat_r <= rdata;
  end

  // machine external interrupt to the hart
  assign o_meip = |pend_en;

endmodule

//--- hdl/periph_soc.sv
`timescale 1ns/1ns

module periph_soc
#(
  parameter int GPIO_WIDTH = 12,
  parameter logic [soc_bus_pkg::CFG_DATA_BITS-1:0] HW_ID = 32'h20240001
)
(
  input  logic                                   i_sys_clk,
  input  logic                                   i_rst,
  // wishbone slave port seen by the cpu
  input  logic                                   i_wb_cyc,
  input  logic                                   i_wb_stb,
  input  logic                                   i_wb_we,
  input  logic [soc_bus_pkg::CFG_ADDR_BITS-1:0]  i_wb_adr,
  input  logic [soc_bus_pkg::CFG_DATA_BITS-1:0]  i_wb_dat,
  output logic [soc_bus_pkg::CFG_DATA_BITS-1:0]  o_wb_dat,
  output logic                                   o_wb_ack,
  output logic                                   o_wb_err,
  // pins
  input  logic [GPIO_WIDTH-1:0]                  i_gpio,
  output logic [GPIO_WIDTH-1:0]                  o_gpio,
  output logic [GPIO_WIDTH-1:0]                  o_gpio_dir,
  input  logic                                   i_ext_irq,
  // interrupts to the hart
  output logic                                   o_mtip,
  output logic                                   o_meip
);
  import soc_bus_pkg::*;

  logic w_irq_gpio;
  logic [CFG_IRQ_TOTAL-1:0] wb_irq_vec;

  wb_slave_if slv_if [CFG_SLV_TOTAL] ();

  ////////////////////
  // bus controller
  ////////////////////
  wb_bus_ctrl ctrl0 (
    .i_sys_clk(i_sys_clk), .i_rst(i_rst),
    .i_cyc(i_wb_cyc), .i_stb(i_wb_stb), .i_we(i_wb_we), .i_adr(i_wb_adr), .i_dat(i_wb_dat),
    .o_dat(o_wb_dat), .o_ack(o_wb_ack), .o_err(o_wb_err),
    .slaves(slv_if)
  );

  ////////////////////
  // slaves
  ////////////////////
  wb_pnp #(.HW_ID(HW_ID)) pnp0 (
    .i_sys_clk(i_sys_clk), .i_rst(i_rst), .bus(slv_if[CFG_SLOT_PNP])
  );

  wb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) gpio0 (
    .i_sys_clk(i_sys_clk), .i_rst(i_rst), .bus(slv_if[CFG_SLOT_GPIO]),
    .i_gpio(i_gpio), .o_gpio(o_gpio), .o_gpio_dir(o_gpio_dir), .o_irq(w_irq_gpio)
  );

  wb_timer timer0 (
    .i_sys_clk(i_sys_clk), .i_rst(i_rst), .bus(slv_if[CFG_SLOT_TIMER]), .o_mtip(o_mtip)
  );

  // interrupt vector, id 0 tied to ground
  assign wb_irq_vec[0] = 1'b0;
  assign wb_irq_vec[IRQ_ID_GPIO] = w_irq_gpio;
  assign wb_irq_vec[IRQ_ID_TIMER] = o_mtip;
  assign wb_irq_vec[IRQ_ID_EXT] = i_ext_irq;

  wb_irq_ctrl irq0 (
    .i_sys_clk(i_sys_clk), .i_rst(i_rst), .bus(slv_if[CFG_SLOT_IRQ]),
    .i_irq(wb_irq_vec), .o_meip(o_meip)
  );

endmodule

//--- sim/periph_soc_chk.sv
`timescale 1ns/1ns

module periph_soc_chk
(
  input logic i_sys_clk,
  input logic i_rst,
  input logic i_cyc,
  input logic i_stb,
  input logic i_ack,
  input logic i_err
);

  // failed assertions, read by the testbench at the end
  int unsigned fail_cnt = 0;

  ////////////////////
  // handshake rules
  ////////////////////
  // ack and err are exclusive
  a_ack_err_excl: assert property (@(posedge i_sys_clk) disable iff (i_rst)
    !(i_ack && i_err))
  else
  begin
    $error("ack and err high together");
    fail_cnt++;
  end

  // a response needs a strobe in the cycle before
  a_resp_after_stb: assert property (@(posedge i_sys_clk) disable iff (i_rst)
    (i_ack || i_err) |-> $past(i_cyc && i_stb))
  else
  begin
    $error("response without a preceding strobe");
    fail_cnt++;
  end

  // new strobe ends on the next clock
  a_one_cycle: assert property (@(posedge i_sys_clk) disable iff (i_rst)
    (i_cyc && i_stb && !i_ack && !i_err) |=> (i_ack || i_err))
  else
  begin
    $error("transfer did not end one cycle after the strobe");
    fail_cnt++;
  end

endmodule

bind wb_bus_ctrl periph_soc_chk chk0 (
  .i_sys_clk(i_sys_clk),
  .i_rst(i_rst),
  .i_cyc(i_cyc),
  .i_stb(i_stb),
  .i_ack(o_ack),
  .i_err(o_err)
);

//--- sim/tb_periph_soc.sv
`timescale 1ns/1ns

module tb_periph_soc;
  import soc_bus_pkg::*;

  localparam int GPIO_W = 12;
  localparam logic [31:0] HW_ID = 32'h20240001;
  localparam int RESET_CYCLES = 8;
  localparam int GPIO_ITER = 8;
  localparam int UNMAP_ITER = 8;
  // transfers per test, last term is slack for the timer wait and pin settling
  localparam int XFER_TOTAL = 6 + 5 * GPIO_ITER + 2 * UNMAP_ITER + 8 + 12 + 8;
  localparam int TIMEOUT_CYCLES = XFER_TOTAL * 10 + RESET_CYCLES;

  logic clk;
  logic rst;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [15:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;
  logic wb_err;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_dir;
  logic ext_irq;
  logic mtip;
  logic meip;

  integer seed;
  string cur_test;
  int test_errs;
  int err_total;
  int tests_run;
  int tests_failed;

  // reference model
  logic [GPIO_W-1:0] m_out;
  logic [GPIO_W-1:0] m_dir;
  logic [GPIO_W-1:0] m_ie;
  logic [CFG_IRQ_TOTAL-1:0] m_pend;
  logic [31:0] m_cfg [6];

  periph_soc #(.GPIO_WIDTH(GPIO_W), .HW_ID(HW_ID)) periph_soc_inst (
    .i_sys_clk(clk), .i_rst(rst),
    .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_adr(wb_adr),
    .i_wb_dat(wb_dat_w), .o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack), .o_wb_err(wb_err),
    .i_gpio(gpio_in), .o_gpio(gpio_out), .o_gpio_dir(gpio_dir), .i_ext_irq(ext_irq),
    .o_mtip(mtip), .o_meip(meip)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // byte address from slot and register offset
  function automatic logic [15:0] reg_addr(int slot, reg_off_t off);
    return {4'(slot), off};
  endfunction

  task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
    $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
    test_errs++;
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    err_total += test_errs;
    if (test_errs == 0)
    begin
      $display("PASS %s", cur_test);
    end
    else
    begin
      $display("FAIL %s: %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  ////////////////////
  // bus driver
  ////////////////////
  // classic single transfer, the response must be there one clock after the strobe
  task automatic bus_xfer(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                          input logic exp_err, output logic [31:0] rdat);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    @(negedge clk);
    if (!exp_err && !wb_ack)
    begin
      $display("%s: ack missing one cycle after the strobe to %h", cur_test, adr);
      test_errs++;
    end
    if (exp_err && !wb_err)
    begin
      $display("%s: err missing one cycle after the strobe to %h", cur_test, adr);
      test_errs++;
    end
    if (exp_err && wb_ack)
    begin
      $display("%s: ack raised for unmapped address %h", cur_test, adr);
      test_errs++;
    end
    if (!exp_err && wb_err)
    begin
      $display("%s: err raised for mapped address %h", cur_test, adr);
      test_errs++;
    end
    rdat = wb_dat_r;
    // strobe low for at least one clock before the next transfer
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic bus_write(input logic [15:0] adr, input logic [31:0] wdat);
    logic [31:0] unused_rd;
    bus_xfer(1'b1, adr, wdat, 1'b0, unused_rd);
  endtask

  task automatic bus_read(input logic [15:0] adr, output logic [31:0] rdat);
    bus_xfer(1'b0, adr, 32'h0, 1'b0, rdat);
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic check_config_table();
    logic [31:0] rd;
    begin_test("config_table");
    for (int i = 0; i < 6; i++)
    begin
      bus_read(reg_addr(CFG_SLOT_PNP, reg_off_t'(4 * i)), rd);
      if (rd !== m_cfg[i])
        report_mismatch($sformatf("word %0d", i), m_cfg[i], rd);
    end
    end_test();
  endtask

  task automatic check_gpio_regs();
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [GPIO_W-1:0] pins;
    begin_test("gpio_regs");
    for (int i = 0; i < GPIO_ITER; i++)
    begin
      rnd = $random(seed);
      m_out = rnd[GPIO_W-1:0];
      m_dir = rnd[GPIO_W+15:16];
      bus_write(reg_addr(CFG_SLOT_GPIO, GPIO_REG_OUT), 32'(m_out));
      bus_write(reg_addr(CFG_SLOT_GPIO, GPIO_REG_DIR), 32'(m_dir));
      bus_read(reg_addr(CFG_SLOT_GPIO, GPIO_REG_OUT), rd);
      if (rd !== 32'(m_out))
        report_mismatch("output reg", 32'(m_out), rd);
      bus_read(reg_addr(CFG_SLOT_GPIO, GPIO_REG_DIR), rd);
      if (rd !== 32'(m_dir))
        report_mismatch("direction reg", 32'(m_dir), rd);
      if (gpio_out !== m_out)
        report_mismatch("o_gpio", 32'(m_out), 32'(gpio_out));
      if (gpio_dir !== m_dir)
        report_mismatch("o_gpio_dir", 32'(m_dir), 32'(gpio_dir));
      // input path goes through two synchroniser flops
      rnd = $random(seed);
      pins = rnd[GPIO_W-1:0];
      gpio_in = pins;
      repeat (2) @(negedge clk);
      bus_read(reg_addr(CFG_SLOT_GPIO, GPIO_REG_IN), rd);
      if (rd !== 32'(pins))
        report_mismatch("input reg", 32'(pins), rd);
    end
    end_test();
  endtask

  task automatic check_unmapped();
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [15:0] adr;
    logic [3:0] region;
    begin_test("unmapped");
    for (int i = 0; i < UNMAP_ITER; i++)
    begin
      rnd = $random(seed);
      // regions 4 to 15 have no slave
      region = 4'(4 + rnd[7:0] % 12);
      adr = {region, rnd[17:8], 2'b00};
      // odd passes read, even passes write
      bus_xfer((i % 2) == 0, adr, rnd, 1'b1, rd);
      if ((i % 2) == 1 && rd !== 32'h0)
        report_mismatch("unmapped read data", 32'h0, rd);
      // a mapped slave still answers afterwards
      bus_read(reg_addr(CFG_SLOT_PNP, PNP_REG_HW_ID), rd);
      if (rd !== HW_ID)
        report_mismatch("hw id after err", HW_ID, rd);
    end
    end_test();
  endtask

  task automatic check_timer();
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] hi;
    logic [63:0] cmp;
    begin_test("timer");
    bus_read(reg_addr(CFG_SLOT_TIMER, TIMER_REG_MTIME_LO), t0);
    bus_read(reg_addr(CFG_SLOT_TIMER, TIMER_REG_MTIME_LO), t1);
    // expected column shows the lowest value accepted
    if (t1 <= t0)
      report_mismatch("second mtime read", t0 + 32'd1, t1);
    bus_read(reg_addr(CFG_SLOT_TIMER, TIMER_REG_MTIME_LO), t0);
    bus_read(reg_addr(CFG_SLOT_TIMER, TIMER_REG_MTIME_HI), hi);
    cmp = {hi, t0} + 64'd50;
    bus_write(reg_addr(CFG_SLOT_TIMER, TIMER_REG_CMP_LO), cmp[31:0]);
    bus_write(reg_addr(CFG_SLOT_TIMER, TIMER_REG_CMP_HI), cmp[63:32]);
    if (mtip !== 1'b0)
      report_mismatch("o_mtip before compare", 32'h0, 32'(mtip));
    repeat (60) @(negedge clk);
    if (mtip !== 1'b1)
      report_mismatch("o_mtip after compare", 32'h1, 32'(mtip));
    // the interrupt controller latches this rise
    m_pend[IRQ_ID_TIMER] = 1'b1;
    bus_write(reg_addr(CFG_SLOT_TIMER, TIMER_REG_CMP_LO), 32'hffffffff);
    bus_write(reg_addr(CFG_SLOT_TIMER, TIMER_REG_CMP_HI), 32'hffffffff);
    if (mtip !== 1'b0)
      report_mismatch("o_mtip after compare reset", 32'h0, 32'(mtip));
    end_test();
  endtask

  task automatic check_irq_flow();
    logic [31:0] rnd;
    logic [31:0] rd;
    int pin;
    begin_test("irq_flow");
    // quiet pins and an empty gpio pending register first
    gpio_in = '0;
    repeat (4) @(negedge clk);
    bus_write(reg_addr(CFG_SLOT_GPIO, GPIO_REG_PEND), 32'hffffffff);
    bus_read(reg_addr(CFG_SLOT_GPIO, GPIO_REG_PEND), rd);
    if (rd !== 32'h0)
      report_mismatch("gpio pending cleared", 32'h0, rd);
    rnd = $random(seed);
    pin = rnd[7:0] % GPIO_W;
    m_ie = '0;
    m_ie[pin] = 1'b1;
    bus_write(reg_addr(CFG_SLOT_GPIO, GPIO_REG_IE), 32'(m_ie));
    bus_write(reg_addr(CFG_SLOT_IRQ, IRQ_REG_ENABLE),
              32'((1 << IRQ_ID_GPIO) | (1 << IRQ_ID_EXT)));
    // one rising edge on the pin and on the external line
    gpio_in[pin] = 1'b1;
    ext_irq = 1'b1;
    m_pend[IRQ_ID_GPIO] = 1'b1;
    m_pend[IRQ_ID_EXT] = 1'b1;
    repeat (5) @(negedge clk);
    bus_read(reg_addr(CFG_SLOT_IRQ, IRQ_REG_PENDING), rd);
    if (rd !== 32'(m_pend))
      report_mismatch("irq pending", 32'(m_pend), rd);
    if (meip !== 1'b1)
      report_mismatch("o_meip raised", 32'h1, 32'(meip));
    // lowest enabled id first, each claim drops its bit
    bus_read(reg_addr(CFG_SLOT_IRQ, IRQ_REG_CLAIM), rd);
    if (rd !== 32'(IRQ_ID_GPIO))
      report_mismatch("first claim", 32'(IRQ_ID_GPIO), rd);
    m_pend[IRQ_ID_GPIO] = 1'b0;
    bus_read(reg_addr(CFG_SLOT_IRQ, IRQ_REG_CLAIM), rd);
    if (rd !== 32'(IRQ_ID_EXT))
      report_mismatch("second claim", 32'(IRQ_ID_EXT), rd);
    m_pend[IRQ_ID_EXT] = 1'b0;
    bus_read(reg_addr(CFG_SLOT_IRQ, IRQ_REG_CLAIM), rd);
    if (rd !== 32'h0)
      report_mismatch("third claim", 32'h0, rd);
    bus_write(reg_addr(CFG_SLOT_GPIO, GPIO_REG_PEND), 32'(m_ie));
    @(negedge clk);
    if (meip !== 1'b0)
      report_mismatch("o_meip cleared", 32'h0, 32'(meip));
    // only the unclaimed timer bit is left
    bus_read(reg_addr(CFG_SLOT_IRQ, IRQ_REG_PENDING), rd);
    if (rd !== 32'(m_pend))
      report_mismatch("irq pending after claims", 32'(m_pend), rd);
    ext_irq = 1'b0;
    end_test();
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial
  begin
    int chk_fails;
    seed = 32'h6551b8da;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    gpio_in = '0;
    ext_irq = 1'b0;
    err_total = 0;
    tests_run = 0;
    tests_failed = 0;
    m_out = '0;
    m_dir = '0;
    m_ie = '0;
    m_pend = '0;
    m_cfg[0] = HW_ID;
    m_cfg[1] = 32'd4;
    m_cfg[2] = {16'h0, DEV_ID_PNP};
    m_cfg[3] = {16'h0, DEV_ID_GPIO};
    m_cfg[4] = {16'h0, DEV_ID_TIMER};
    m_cfg[5] = {16'h0, DEV_ID_IRQ};
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_config_table();
    check_gpio_regs();
    check_unmapped();
    check_timer();
    check_irq_flow();
    // assertion failures seen by the bound checker
    chk_fails = periph_soc_inst.ctrl0.chk0.fail_cnt;
    if (chk_fails != 0)
    begin
      $display("bound checker saw %0d assertion failures", chk_fails);
      err_total += chk_fails;
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_total);
    if (err_total == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- build.f
hdl/soc_bus_pkg.sv
hdl/wb_slave_if.sv
hdl/wb_bus_ctrl.sv
hdl/wb_pnp.sv
hdl/wb_gpio.sv
hdl/wb_timer.sv
hdl/wb_irq_ctrl.sv
hdl/periph_soc.sv
sim/periph_soc_chk.sv
sim/tb_periph_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the periph_soc testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 --top-module tb_periph_soc -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench can count them
"$OBJ/Vtb_periph_soc" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0
